// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -f vlog.f --top-module cpu_tb -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/Vcpu_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// First fetch address after reset
`define CPU_RESET_VECTOR 32'hBFC00000

// Size of the general purpose register file
`define CPU_REG_COUNT 32

// Destination of jal, bgezal and bltzal
`define CPU_LINK_REG 5'd31

`endif

// File: rtl/alu.sv
module alu import cpu_pkg::*; (
    input logic clk,
    input logic reset,
    input logic exec1,
    input word_t rs_data,
    input word_t rt_data,
    input logic use_imm,
    output word_t result,
    branch_if.alu_side br
);

    word_t imm_ext;
    word_t operand_b;
    word_t alu_out;
    word_t compare;
    logic compare_pair;

    assign imm_ext = {{16{br.offset[15]}}, br.offset};
    assign operand_b = use_imm ? imm_ext : rt_data;

    always_comb begin
        case (br.instruction_code)
            ic_addu, ic_addiu: alu_out = rs_data + operand_b;
            ic_subu: alu_out = rs_data - operand_b;
            ic_and: alu_out = rs_data & operand_b;
            ic_or: alu_out = rs_data | operand_b;
            ic_lui: alu_out = {br.offset, 16'h0000};
            default: alu_out = '0;
        endcase
    end

    // beq and bne compare rs with rt, every other branch compares rs with zero
    assign compare_pair = (br.instruction_code == ic_beq) || (br.instruction_code == ic_bne);
    assign compare = compare_pair ? (rs_data - rt_data) : rs_data;

    always_ff @(posedge clk) begin
        if (exec1) begin
            result <= alu_out;
            br.register_data <= rs_data;   // Jump target for jr and jalr
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            br.zero <= 1'b0;
            br.positive <= 1'b0;
            br.negative <= 1'b0;
        end else if (exec1) begin
            br.zero <= (compare == '0);
            br.positive <= (compare != '0) && !compare[31];
            br.negative <= compare[31];
        end
    end

endmodule

// File: rtl/branch_if.sv
interface branch_if import cpu_pkg::*; ();

    instr_code_t instruction_code;
    offset_t offset;
    instr_index_t instr_index;
    word_t register_data;   // Value of rs latched in exec1
    logic zero;
    logic positive;
    logic negative;

    modport decoder_side (output instruction_code, offset, instr_index);

    // The ALU needs the code and the immediate to pick its operation
    modport alu_side (input instruction_code, offset,
                      output register_data, zero, positive, negative);

    modport pc_side (input instruction_code, offset, instr_index, register_data,
                     zero, positive, negative);

endinterface

// File: rtl/cpu_core.sv
module cpu_core import cpu_pkg::*; (
    input logic clk,
    input logic reset,
    output word_t instr_addr,
    input word_t instr_data,
    output logic wb_enable,
    output reg_index_t wb_index,
    output word_t wb_data,
    output logic halted
);

    logic fetch;
    logic exec1;
    logic exec2;
    logic pc_halt;
    reg_index_t rs;
    reg_index_t rt;
    reg_index_t wr_index;
    logic wr_enable;
    logic use_link;
    logic use_imm;
    word_t rs_data;
    word_t rt_data;
    word_t result;
    word_t return_address;

    branch_if br ();

    cycle_sequencer u_sequencer (
        .clk(clk), .reset(reset), .pc_halt(pc_halt),
        .fetch(fetch), .exec1(exec1), .exec2(exec2), .halted(halted)
    );

    instruction_decoder u_decoder (
        .clk(clk), .reset(reset), .fetch(fetch), .instr_data(instr_data),
        .rs(rs), .rt(rt), .wr_index(wr_index), .wr_enable(wr_enable),
        .use_link(use_link), .use_imm(use_imm), .br(br.decoder_side)
    );

    register_file u_regs (
        .clk(clk), .reset(reset), .rs(rs), .rt(rt), .rs_data(rs_data), .rt_data(rt_data),
        .write(wb_enable), .wr_index(wb_index), .wr_data(wb_data)
    );

    alu u_alu (
        .clk(clk), .reset(reset), .exec1(exec1), .rs_data(rs_data), .rt_data(rt_data),
        .use_imm(use_imm), .result(result), .br(br.alu_side)
    );

    program_counter u_pc (
        .clk(clk), .reset(reset), .fetch(fetch), .exec2(exec2), .br(br.pc_side),
        .address(instr_addr), .return_address(return_address), .pc_halt(pc_halt)
    );

    assign wb_enable = exec2 && wr_enable;
    assign wb_index = wr_index;
    assign wb_data = use_link ? return_address : result;   // Links write the return address

endmodule

// File: rtl/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_index_t;
    typedef logic [6:0] instr_code_t;
    typedef logic [15:0] offset_t;
    typedef logic [25:0] instr_index_t;

    typedef enum logic [1:0] {
        state_fetch,
        state_exec1,
        state_exec2,
        state_halted
    } cycle_state_t;

    // Internal instruction codes, anything not listed decodes to ic_nop
    localparam instr_code_t ic_nop = 7'd0;
    localparam instr_code_t ic_addu = 7'd1;
    localparam instr_code_t ic_subu = 7'd2;
    localparam instr_code_t ic_and = 7'd3;
    localparam instr_code_t ic_or = 7'd4;
    localparam instr_code_t ic_addiu = 7'd5;
    localparam instr_code_t ic_lui = 7'd6;

    // Control flow codes start at 30
    localparam instr_code_t ic_beq = 7'd30;
    localparam instr_code_t ic_bgez = 7'd31;
    localparam instr_code_t ic_bgezal = 7'd32;
    localparam instr_code_t ic_bgtz = 7'd33;
    localparam instr_code_t ic_blez = 7'd34;
    localparam instr_code_t ic_bltz = 7'd35;
    localparam instr_code_t ic_bltzal = 7'd36;
    localparam instr_code_t ic_bne = 7'd37;
    localparam instr_code_t ic_j = 7'd38;
    localparam instr_code_t ic_jal = 7'd39;
    localparam instr_code_t ic_jalr = 7'd40;
    localparam instr_code_t ic_jr = 7'd41;

endpackage

// File: rtl/cycle_sequencer.sv
module cycle_sequencer import cpu_pkg::*; (
    input logic clk,
    input logic reset,
    input logic pc_halt,
    output logic fetch,
    output logic exec1,
    output logic exec2,
    output logic halted
);

    cycle_state_t state;
    cycle_state_t state_next;

    always_comb begin
        state_next = state;
        if (pc_halt) begin
            state_next = state_halted;   // Stays here until reset
        end else begin
            case (state)
                state_fetch: state_next = state_exec1;
                state_exec1: state_next = state_exec2;
                state_exec2: state_next = state_fetch;
                default: state_next = state_halted;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= state_fetch;
        end else begin
            state <= state_next;
        end
    end

    assign fetch = (state == state_fetch);
    assign exec1 = (state == state_exec1);
    assign exec2 = (state == state_exec2);
    assign halted = (state == state_halted);

endmodule

// File: rtl/instruction_decoder.sv
`include "cpu_settings.svh"

module instruction_decoder import cpu_pkg::*; (
    input logic clk,
    input logic reset,
    input logic fetch,
    input word_t instr_data,
    output reg_index_t rs,
    output reg_index_t rt,
    output reg_index_t wr_index,
    output logic wr_enable,
    output logic use_link,
    output logic use_imm,
    branch_if.decoder_side br
);

    word_t ir;
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_index_t rd;
    instr_code_t code;
    logic writes;

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;   // Decodes as nop
        end else if (fetch) begin
            ir <= instr_data;
        end
    end

    assign opcode = ir[31:26];
    assign funct = ir[5:0];
    assign rs = ir[25:21];
    assign rt = ir[20:16];
    assign rd = ir[15:11];

    always_comb begin
        code = ic_nop;
        case (opcode)
            6'h00: begin
                case (funct)
                    6'h08: code = ic_jr;
                    6'h09: code = ic_jalr;
                    6'h21: code = ic_addu;
                    6'h23: code = ic_subu;
                    6'h24: code = ic_and;
                    6'h25: code = ic_or;
                    default: code = ic_nop;
                endcase
            end
            6'h01: begin
                case (rt)   // REGIMM selects the branch by the rt field
                    5'h00: code = ic_bltz;
                    5'h01: code = ic_bgez;
                    5'h10: code = ic_bltzal;
                    5'h11: code = ic_bgezal;
                    default: code = ic_nop;
                endcase
            end
            6'h02: code = ic_j;
            6'h03: code = ic_jal;
            6'h04: code = ic_beq;
            6'h05: code = ic_bne;
            6'h06: code = ic_blez;
            6'h07: code = ic_bgtz;
            6'h09: code = ic_addiu;
            6'h0f: code = ic_lui;
            default: code = ic_nop;
        endcase
    end

    always_comb begin
        wr_index = rd;
        writes = 1'b0;
        use_link = 1'b0;
        use_imm = 1'b0;
        case (code)
            ic_addu, ic_subu, ic_and, ic_or: writes = 1'b1;
            ic_addiu, ic_lui: begin
                writes = 1'b1;
                use_imm = 1'b1;
                wr_index = rt;
            end
            ic_jalr: begin
                writes = 1'b1;
                use_link = 1'b1;
            end
            ic_jal, ic_bgezal, ic_bltzal: begin
                writes = 1'b1;   // Links even when the branch is not taken
                use_link = 1'b1;
                wr_index = `CPU_LINK_REG;
            end
            default: writes = 1'b0;
        endcase
    end

    assign wr_enable = writes && (wr_index != '0);

    assign br.instruction_code = code;
    assign br.offset = ir[15:0];
    assign br.instr_index = ir[25:0];

endmodule

// File: rtl/program_counter.sv
`include "cpu_settings.svh"

module program_counter import cpu_pkg::*; (
    input logic clk,
    input logic reset,
    input logic fetch,
    input logic exec2,
    branch_if.pc_side br,
    output word_t address,
    output word_t return_address,
    output logic pc_halt
);

    word_t inst_addr;
    word_t branch_target;
    word_t jump_address;
    word_t next_address;
    logic jump;

    assign branch_target = inst_addr + {{14{br.offset[15]}}, br.offset, 2'b00};

    always_comb begin
        jump_address = branch_target;
        jump = 1'b0;
        case (br.instruction_code)
            ic_beq: jump = br.zero;
            ic_bne: jump = br.positive || br.negative;
            ic_bgtz: jump = br.positive;
            ic_blez: jump = br.zero || br.negative;
            ic_bgez, ic_bgezal: jump = br.positive || br.zero;
            ic_bltz, ic_bltzal: jump = br.negative;
            ic_jr, ic_jalr: begin
                jump_address = br.register_data;
                jump = 1'b1;
            end
            ic_j, ic_jal: begin
                jump_address = {inst_addr[31:28], br.instr_index, 2'b00};
                jump = 1'b1;
            end
            default: jump = 1'b0;
        endcase
    end

    // By exec2 address already points at the following instruction
    assign next_address = jump ? jump_address : address;

    // No delay slot, so the word after a link is skipped
    assign return_address = inst_addr + 32'd8;

    always_ff @(posedge clk) begin
        if (fetch) begin
            inst_addr <= address;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            address <= `CPU_RESET_VECTOR;
            pc_halt <= 1'b0;
        end else if (!pc_halt) begin
            if (fetch) begin
                address <= address + 32'd4;
            end else if (exec2) begin
                address <= next_address;
                if (next_address == '0) begin
                    pc_halt <= 1'b1;   // Sticky, only reset clears it
                end
            end
        end
    end

endmodule

// File: rtl/register_file.sv
`include "cpu_settings.svh"

module register_file import cpu_pkg::*; (
    input logic clk,
    input logic reset,
    input reg_index_t rs,
    input reg_index_t rt,
    output word_t rs_data,
    output word_t rt_data,
    input logic write,
    input reg_index_t wr_index,
    input word_t wr_data
);

    word_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write && (wr_index != '0)) begin
            regs[wr_index] <= wr_data;
        end
    end

    // Register 0 is cleared by reset and never written
    assign rs_data = regs[rs];
    assign rt_data = regs[rt];

endmodule

// File: verification/cpu_sva.sv
module cpu_sva import cpu_pkg::*; (
    input logic clk,
    input logic reset,
    input logic fetch,
    input logic exec1,
    input logic exec2,
    input logic halted,
    input word_t instr_addr
);

    a_fetch_then_exec1: assert property (@(posedge clk) disable iff (reset)
        fetch |=> exec1 || halted)
        else $error("fetch was not followed by exec1 or a halt");

    a_exec1_then_exec2: assert property (@(posedge clk) disable iff (reset)
        exec1 |=> exec2)
        else $error("exec1 was not followed by exec2");

    a_exec2_then_fetch: assert property (@(posedge clk) disable iff (reset)
        exec2 |=> fetch)
        else $error("exec2 was not followed by fetch");

    a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
        else $error("halted dropped without reset");

    // The core only stops once control has reached address 0
    a_halt_at_zero: assert property (@(posedge clk) disable iff (reset)
        halted |-> instr_addr == '0)
        else $error("halted with a non-zero fetch address");

endmodule

// The strobes and the fetch address meet in the core
bind cpu_core cpu_sva u_cpu_sva (
    .clk(clk), .reset(reset), .fetch(fetch), .exec1(exec1), .exec2(exec2),
    .halted(halted), .instr_addr(instr_addr)
);

// File: verification/cpu_tb.sv
`include "cpu_settings.svh"

module cpu_tb import cpu_pkg::*; ();

    logic clk;
    logic reset;
    word_t instr_addr;
    word_t instr_data;
    logic wb_enable;
    reg_index_t wb_index;
    word_t wb_data;
    logic halted;

    word_t imem [256];
    word_t model_regs [32];
    word_t seed = 45907;
    word_t fetch_q[$];
    word_t exp_fetch_q[$];
    word_t wb_data_q[$];
    word_t exp_data_q[$];
    reg_index_t wb_index_q[$];
    reg_index_t exp_index_q[$];
    int fetch_cycle_q[$];
    int cycle_count = 0;
    int pc_idx;
    int errors = 0;
    int test_errors = 0;
    int checks = 0;
    int tests = 0;

    cpu_core uut (
        .clk(clk), .reset(reset), .instr_addr(instr_addr), .instr_data(instr_data),
        .wb_enable(wb_enable), .wb_index(wb_index), .wb_data(wb_data), .halted(halted)
    );

    function automatic word_t addr_of(input int idx);
        return `CPU_RESET_VECTOR + word_t'(idx * 4);
    endfunction

    function automatic word_t fetch_word(input word_t addr);
        word_t offset;
        offset = addr - `CPU_RESET_VECTOR;
        if (offset < 32'd1024) return imem[offset[9:2]];
        return 32'h00000008;   // jr $0 outside the program area
    endfunction

    assign instr_data = fetch_word(instr_addr);   // Combinational instruction memory

    function automatic word_t lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (!reset) begin
            if (uut.fetch) begin
                fetch_q.push_back(instr_addr);
                fetch_cycle_q.push_back(cycle_count);
            end
            if (wb_enable) begin
                wb_index_q.push_back(wb_index);
                wb_data_q.push_back(wb_data);
            end
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_index(input string name, input reg_index_t got, input reg_index_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = {6'h00, 2'b00, i[7:0], 10'd0, 6'h21};   // addu to $0, no write
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        exp_fetch_q.delete();
        exp_index_q.delete();
        exp_data_q.delete();
        pc_idx = 0;
    endtask

    task automatic put(input word_t w);
        imem[pc_idx] = w;
        exp_fetch_q.push_back(addr_of(pc_idx));
        pc_idx++;
    endtask

    task automatic write_model(input reg_index_t r, input word_t v);
        if (r != 5'd0) begin
            model_regs[r] = v;
            exp_index_q.push_back(r);
            exp_data_q.push_back(v);
        end
    endtask

    task automatic emit_r(input logic [5:0] funct, input reg_index_t rd, input reg_index_t rs,
                          input reg_index_t rt);
        word_t v;
        case (funct)
            6'h21: v = model_regs[rs] + model_regs[rt];
            6'h23: v = model_regs[rs] - model_regs[rt];
            6'h24: v = model_regs[rs] & model_regs[rt];
            default: v = model_regs[rs] | model_regs[rt];
        endcase
        put({6'h00, rs, rt, rd, 5'd0, funct});
        write_model(rd, v);
    endtask

    task automatic emit_addiu(input reg_index_t rt, input reg_index_t rs, input offset_t imm);
        put({6'h09, rs, rt, imm});
        write_model(rt, model_regs[rs] + {{16{imm[15]}}, imm});
    endtask

    task automatic emit_lui(input reg_index_t rt, input offset_t imm);
        put({6'h0f, 5'd0, rt, imm});
        write_model(rt, {imm, 16'h0000});
    endtask

    task automatic load_const(input reg_index_t r, input word_t v);
        emit_lui(r, v[31:16] + {15'd0, v[15]});   // Undo the sign extension of the low half
        emit_addiu(r, r, v[15:0]);
    endtask

    task automatic emit_halt();
        put(32'h00000008);
        exp_fetch_q.push_back(32'h0);   // One fetch from address 0 before the halt
    endtask

    task automatic check_queues();
        if (fetch_q.size() != exp_fetch_q.size() || wb_data_q.size() != exp_data_q.size()) begin
            $display("Fetch or write count differs: fetches %0d of %0d, writes %0d of %0d",
                     fetch_q.size(), exp_fetch_q.size(), wb_data_q.size(), exp_data_q.size());
            test_errors++;
        end
        for (int i = 0; i < fetch_q.size() && i < exp_fetch_q.size(); i++) begin
            check_word("instr_addr", fetch_q[i], exp_fetch_q[i]);
        end
        for (int i = 0; i < wb_data_q.size() && i < exp_data_q.size(); i++) begin
            check_index("wb_index", wb_index_q[i], exp_index_q[i]);
            check_word("wb_data", wb_data_q[i], exp_data_q[i]);
        end
    endtask

    task automatic run_program();
        int n;
        @(posedge clk);
        reset <= 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        fetch_q.delete();
        fetch_cycle_q.delete();
        wb_index_q.delete();
        wb_data_q.delete();
        @(negedge clk);
        check_word("instr_addr", instr_addr, `CPU_RESET_VECTOR);
        n = 0;
        while (!halted && n < 3000) begin
            @(negedge clk);
            n++;
        end
        if (!halted) begin
            $display("Timeout: the core did not halt within 3000 cycles");
            test_errors++;
        end else begin
            check_queues();
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) $display("%s: ok", name);
        else $display("%s: %0d errors", name, test_errors);
        errors += test_errors;
        test_errors = 0;
        tests++;
    endtask

    task automatic test_reset_fetch();
        clear_program();
        put(32'h0);
        put(32'h0);
        put(32'h0);
        emit_halt();
        run_program();
        for (int i = 1; i < 3 && i < fetch_cycle_q.size(); i++) begin
            if (fetch_cycle_q[i] - fetch_cycle_q[i - 1] != 3) begin
                $display("Fetches %0d and %0d are not three cycles apart", i - 1, i);
                test_errors++;
            end
        end
        finish_test("reset_fetch");
    endtask

    task automatic test_alu();
        word_t r;
        clear_program();
        for (int k = 0; k < 3; k++) begin
            load_const(5'd1, lcg_next());
            load_const(5'd2, lcg_next());
            emit_r(6'h21, 5'd3, 5'd1, 5'd2);
            emit_r(6'h23, 5'd4, 5'd1, 5'd2);
            emit_r(6'h24, 5'd5, 5'd1, 5'd2);
            emit_r(6'h25, 5'd6, 5'd1, 5'd2);
            r = lcg_next();
            emit_addiu(5'd7, 5'd1, r[15:0]);
            emit_lui(5'd8, r[31:16]);
            emit_addiu(5'd0, 5'd1, r[15:0]);
            emit_r(6'h21, 5'd0, 5'd1, 5'd2);
        end
        emit_halt();
        run_program();
        finish_test("alu");
    endtask

    function automatic word_t branch_word(input int kind, input offset_t off);
        case (kind)
            0: return {6'h04, 5'd1, 5'd2, off};   // beq
            1: return {6'h05, 5'd1, 5'd2, off};   // bne
            2: return {6'h06, 5'd1, 5'd0, off};   // blez
            3: return {6'h07, 5'd1, 5'd0, off};   // bgtz
            4: return {6'h01, 5'd1, 5'h00, off};   // bltz
            5: return {6'h01, 5'd1, 5'h01, off};   // bgez
            6: return {6'h01, 5'd1, 5'h10, off};   // bltzal
            default: return {6'h01, 5'd1, 5'h11, off};   // bgezal
        endcase
    endfunction

    function automatic bit branch_taken(input int kind, input word_t a, input word_t b);
        word_t d;
        bit z;
        bit n;
        d = (kind < 2) ? a - b : a;
        z = (d == 32'h0);
        n = d[31];
        case (kind)
            0: return z;
            1: return !z;
            2: return z || n;
            3: return !z && !n;
            4, 6: return n;
            default: return !n;
        endcase
    endfunction

    task automatic test_branches();
        word_t a;
        word_t b;
        word_t d;
        int i;
        int dest;
        for (int kind = 0; kind < 8; kind++) begin
            for (int cls = 0; cls < 3; cls++) begin
                clear_program();
                d = lcg_next();
                if (cls == 0) d = {1'b1, d[30:0]};
                else if (cls == 1) d = 32'h0;
                else d = {1'b0, d[30:1], 1'b1};
                b = lcg_next();
                a = (kind < 2) ? b + d : d;
                load_const(5'd1, a);
                load_const(5'd2, b);
                i = pc_idx;
                put(branch_word(kind, 16'd3));
                if (kind >= 6) write_model(5'd31, addr_of(i) + 32'd8);
                place_halt(i + 1);
                place_halt(i + 3);
                dest = branch_taken(kind, a, b) ? i + 3 : i + 1;
                exp_fetch_q.push_back(addr_of(dest));
                exp_fetch_q.push_back(32'h0);
                run_program();
            end
        end
        finish_test("branches");
    endtask

    task automatic place_halt(input int idx);
        imem[idx] = 32'h00000008;
    endtask

    task automatic test_jumps();
        word_t t;
        clear_program();
        t = addr_of(4);
        put({6'h02, t[27:2]});   // j
        pc_idx = 4;
        t = addr_of(8);
        put({6'h03, t[27:2]});   // jal
        write_model(5'd31, addr_of(4) + 32'd8);
        pc_idx = 8;
        load_const(5'd5, addr_of(14));
        put({6'h00, 5'd5, 5'd0, 5'd7, 5'd0, 6'h09});   // jalr $7, $5
        write_model(5'd7, addr_of(10) + 32'd8);
        pc_idx = 14;
        load_const(5'd6, addr_of(20));
        put({6'h00, 5'd6, 15'd0, 6'h08});   // jr $6
        pc_idx = 20;
        put({6'h01, 5'd0, 5'h11, 16'd2});   // bgezal $0, taken
        write_model(5'd31, addr_of(20) + 32'd8);
        pc_idx = 22;
        put({6'h01, 5'd0, 5'h10, 16'd5});   // bltzal $0, not taken
        write_model(5'd31, addr_of(22) + 32'd8);
        emit_halt();
        run_program();
        finish_test("jumps");
    endtask

    task automatic test_halt();
        word_t hold;
        clear_program();
        emit_addiu(5'd3, 5'd0, 16'd0);
        put({6'h00, 5'd3, 15'd0, 6'h08});   // jr $3 with $3 holding 0
        exp_fetch_q.push_back(32'h0);
        run_program();
        hold = instr_addr;
        check_word("instr_addr", hold, 32'h0);
        for (int n = 0; n < 20; n++) begin
            @(negedge clk);
            if (wb_enable) begin
                $display("Register write seen after the core halted");
                test_errors++;
            end
            check_word("instr_addr", instr_addr, hold);
        end
        finish_test("halt");
    endtask

    initial begin
        reset <= 1'b1;
        test_reset_fetch();
        test_alu();
        test_branches();
        test_jumps();
        test_halt();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
rtl/cpu_pkg.sv
rtl/branch_if.sv
rtl/cycle_sequencer.sv
rtl/instruction_decoder.sv
rtl/register_file.sv
rtl/alu.sv
rtl/program_counter.sv
rtl/cpu_core.sv
verification/cpu_sva.sv
verification/cpu_tb.sv
